//--- wb_bus_pkg.sv
// Wishbone host bus widths, access timeout and controller state encoding
`default_nettype none

package wb_bus_pkg;

    // Master address and data widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Cycles after the request strobe before an unanswered access fails
    localparam int TIMEOUT_CYCLES = 16;

    // Counter must be able to hold TIMEOUT_CYCLES itself
    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

    // Host controller states
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        ACCESS   = 2'd1,
        COMPLETE = 2'd2
    } host_state_t;

endpackage

`default_nettype wire

//--- wb_map_pkg.sv
// Slave address map and register reset values for the register bank
`default_nettype none

package wb_map_pkg;

    // Number of register slaves and width of their index field
    localparam int NUM_SLAVES = 8;
    localparam int SEL_W = 3;

    // Slave index sits in address bits [SEL_LSB +: SEL_W]
    localparam int SEL_LSB = 2;

    // Bits from here upward must be zero for a mapped address
    localparam int MAP_TOP_LSB = 5;

    // Slave k resets to REG_RESET_BASE + k * REG_STRIDE
    localparam logic [wb_bus_pkg::DATA_W-1:0] REG_RESET_BASE = 32'h9ABC_DEF0;
    localparam logic [wb_bus_pkg::DATA_W-1:0] REG_STRIDE = 32'h0000_0200;

endpackage

`default_nettype wire

//--- wb_host_ctrl.sv
// Wishbone host controller with request latch, handshake FSM and access timeout
`timescale 1ns/1ps
`default_nettype none

module wb_host_ctrl (
    input  wire                              clk,
    input  wire                              rst,
    input  wire  [wb_bus_pkg::ADDR_W-1:0]    wb_adr_i,
    input  wire  [wb_bus_pkg::DATA_W-1:0]    wb_dat_i,
    input  wire                              wb_cyc_i,
    input  wire                              wb_stb_i,
    input  wire                              wb_we_i,
    output logic [wb_bus_pkg::DATA_W-1:0]    wb_dat_o,
    output logic                             wb_ack_o,
    output logic                             wb_err_o,
    input  wire                              rsp_stb_i,
    input  wire  [wb_bus_pkg::DATA_W-1:0]    rsp_rdata_i,
    output logic                             req_stb_o,
    output logic [wb_bus_pkg::ADDR_W-1:0]    req_adr_o,
    output logic [wb_bus_pkg::DATA_W-1:0]    req_dat_o,
    output logic                             req_we_o
);

    import wb_bus_pkg::*;

    host_state_t      state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             access_start;

    // New access only accepted from IDLE
    assign access_start = (state_q == IDLE) && wb_cyc_i && wb_stb_i;

    // Request payload, held until the next accepted access
    always_ff @(posedge clk) begin
        if (access_start) begin
            req_adr_o <= wb_adr_i;
            req_dat_o <= wb_dat_i;
            req_we_o  <= wb_we_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= IDLE;
            cnt_q     <= '0;
            req_stb_o <= 1'b0;
            wb_ack_o  <= 1'b0;
            wb_err_o  <= 1'b0;
            wb_dat_o  <= '0;
        end else begin
            // Strobes are single-cycle pulses
            req_stb_o <= 1'b0;
            wb_ack_o  <= 1'b0;
            wb_err_o  <= 1'b0;

            case (state_q)
                IDLE: begin
                    if (access_start) begin
                        state_q <= ACCESS;
                        cnt_q   <= '0;
                    end
                end

                ACCESS: begin
                    // First cycle in ACCESS issues the request
                    if (cnt_q == '0) begin
                        req_stb_o <= 1'b1;
                    end

                    if (rsp_stb_i) begin
                        wb_ack_o <= 1'b1;
                        // Read data only replaced on reads
                        if (!req_we_o) begin
                            wb_dat_o <= rsp_rdata_i;
                        end
                        state_q <= COMPLETE;
                    end else if (cnt_q == CNT_W'(TIMEOUT_CYCLES)) begin
                        // Nobody answered, unmapped address
                        wb_err_o <= 1'b1;
                        state_q  <= COMPLETE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end

                COMPLETE: begin
                    // Wait for the master to release stb
                    if (!wb_stb_i) begin
                        state_q <= IDLE;
                    end
                end

                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- wb_slave_decoder.sv
// Address decoder turning the request strobe into a registered one-hot slave select
`timescale 1ns/1ps
`default_nettype none

module wb_slave_decoder (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                req_stb_i,
    input  wire  [wb_bus_pkg::ADDR_W-1:0]      req_adr_i,
    output logic [wb_map_pkg::NUM_SLAVES-1:0]  sel_stb_o
);

    import wb_bus_pkg::*;
    import wb_map_pkg::*;

    logic                  addr_mapped;
    logic [SEL_W-1:0]      slave_idx;
    logic [NUM_SLAVES-1:0] sel_onehot;

    // Upper field must be clear, byte offset bits are ignored
    assign addr_mapped = (req_adr_i[ADDR_W-1:MAP_TOP_LSB] == '0);
    assign slave_idx   = req_adr_i[SEL_LSB +: SEL_W];

    always_comb begin
        sel_onehot = '0;
        if (req_stb_i && addr_mapped) begin
            for (int k = 0; k < NUM_SLAVES; k++) begin
                // Index values past the last slave select nothing
                if (slave_idx == SEL_W'(k)) begin
                    sel_onehot[k] = 1'b1;
                end
            end
        end
    end

    // One register stage between request and select
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_stb_o <= '0;
        end else begin
            sel_stb_o <= sel_onehot;
        end
    end

endmodule

`default_nettype wire

//--- wb_reg_slave.sv
// Word-wide register slave with write on select and single-cycle acknowledge
`timescale 1ns/1ps
`default_nettype none

module wb_reg_slave #(
    parameter int SLAVE_INDEX = 0
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              sel_stb_i,
    input  wire                              req_we_i,
    input  wire  [wb_bus_pkg::DATA_W-1:0]    req_dat_i,
    output logic                             rsp_ack_o,
    output logic [wb_bus_pkg::DATA_W-1:0]    rsp_dat_o
);

    import wb_bus_pkg::*;
    import wb_map_pkg::*;

    // Reset value depends on position in the bank
    localparam logic [DATA_W-1:0] RESET_VALUE =
        REG_RESET_BASE + DATA_W'(SLAVE_INDEX) * REG_STRIDE;

    logic [DATA_W-1:0] reg_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reg_q <= RESET_VALUE;
        end else if (sel_stb_i && req_we_i) begin
            reg_q <= req_dat_i;
        end
    end

    // Ack one cycle after the select strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_ack_o <= 1'b0;
        end else begin
            rsp_ack_o <= sel_stb_i;
        end
    end

    // Register always visible to the response mux
    assign rsp_dat_o = reg_q;

endmodule

`default_nettype wire

//--- wb_response_mux.sv
// Response mux merging slave acknowledges and steering the read data
`timescale 1ns/1ps
`default_nettype none

module wb_response_mux (
    input  wire  [wb_map_pkg::NUM_SLAVES-1:0]  rsp_ack_i,
    input  wire  [wb_bus_pkg::DATA_W-1:0]      rsp_dat_i [wb_map_pkg::NUM_SLAVES],
    output logic                               rsp_stb_o,
    output logic [wb_bus_pkg::DATA_W-1:0]      rsp_rdata_o
);

    import wb_bus_pkg::*;
    import wb_map_pkg::*;

    // At most one slave acknowledges per access
    assign rsp_stb_o = |rsp_ack_i;

    // AND-OR select, zero when nobody answers
    always_comb begin
        rsp_rdata_o = '0;
        for (int k = 0; k < NUM_SLAVES; k++) begin
            rsp_rdata_o = rsp_rdata_o | ({DATA_W{rsp_ack_i[k]}} & rsp_dat_i[k]);
        end
    end

endmodule

`default_nettype wire

//--- wb_host_top.sv
// Wishbone host top level with controller, decoder, register bank and response mux
`timescale 1ns/1ps
`default_nettype none

module wb_host_top (
    input  wire                              clk,
    input  wire                              rst,
    input  wire  [wb_bus_pkg::ADDR_W-1:0]    wb_adr_i,
    input  wire  [wb_bus_pkg::DATA_W-1:0]    wb_dat_i,
    input  wire                              wb_cyc_i,
    input  wire                              wb_stb_i,
    input  wire                              wb_we_i,
    output logic [wb_bus_pkg::DATA_W-1:0]    wb_dat_o,
    output logic                             wb_ack_o,
    output logic                             wb_err_o
);

    import wb_bus_pkg::*;
    import wb_map_pkg::*;

    // Latched request from the controller
    logic                  req_stb;
    logic [ADDR_W-1:0]     req_adr;
    logic [DATA_W-1:0]     req_dat;
    logic                  req_we;

    // Select and response paths
    logic [NUM_SLAVES-1:0] sel_stb;
    logic [NUM_SLAVES-1:0] rsp_ack;
    logic [DATA_W-1:0]     rsp_dat [NUM_SLAVES];
    logic                  rsp_stb;
    logic [DATA_W-1:0]     rsp_rdata;

    wb_host_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .wb_err_o    (wb_err_o),
        .rsp_stb_i   (rsp_stb),
        .rsp_rdata_i (rsp_rdata),
        .req_stb_o   (req_stb),
        .req_adr_o   (req_adr),
        .req_dat_o   (req_dat),
        .req_we_o    (req_we)
    );

    wb_slave_decoder u_decoder (
        .clk       (clk),
        .rst       (rst),
        .req_stb_i (req_stb),
        .req_adr_i (req_adr),
        .sel_stb_o (sel_stb)
    );

    // One register slave per index
    for (genvar k = 0; k < NUM_SLAVES; k++) begin : g_slave
        wb_reg_slave #(
            .SLAVE_INDEX (k)
        ) u_slave (
            .clk       (clk),
            .rst       (rst),
            .sel_stb_i (sel_stb[k]),
            .req_we_i  (req_we),
            .req_dat_i (req_dat),
            .rsp_ack_o (rsp_ack[k]),
            .rsp_dat_o (rsp_dat[k])
        );
    end

    wb_response_mux u_mux (
        .rsp_ack_i   (rsp_ack),
        .rsp_dat_i   (rsp_dat),
        .rsp_stb_o   (rsp_stb),
        .rsp_rdata_o (rsp_rdata)
    );

endmodule

`default_nettype wire

//--- wb_host_checker.sv
// Wishbone host checker keeping a register model and comparing the master-side responses
`timescale 1ns/1ps
`default_nettype none

module wb_host_checker (
    input  wire                              clk,
    input  wire                              rst,
    input  wire  [wb_bus_pkg::ADDR_W-1:0]    adr_i,
    input  wire  [wb_bus_pkg::DATA_W-1:0]    wdat_i,
    input  wire                              cyc_i,
    input  wire                              stb_i,
    input  wire                              we_i,
    input  wire  [wb_bus_pkg::DATA_W-1:0]    rdat_i,
    input  wire                              ack_i,
    input  wire                              err_i,
    output int                               error_count_o,
    output int                               done_count_o
);

    import wb_bus_pkg::*;
    import wb_map_pkg::*;

    // Model state mirrors the controller state after the last rising edge
    logic [DATA_W-1:0] model_reg [NUM_SLAVES];
    host_state_t       model_state;
    logic              start_pending;
    int                age;
    int                idx;
    logic [ADDR_W-1:0] acc_adr;
    logic [DATA_W-1:0] acc_dat;
    logic              acc_we;
    logic [DATA_W-1:0] exp_dat;
    logic              exp_ack;
    logic              exp_err;
    int                err_cnt = 0;
    int                done_cnt = 0;

    assign error_count_o = err_cnt;
    assign done_count_o  = done_cnt;

    task automatic report_mismatch(input string name, input logic [DATA_W-1:0] exp_val,
                                   input logic [DATA_W-1:0] act_val);
        err_cnt++;
        $display("** Error at time %0t: %s expected %0h actual %0h",
                 $time, name, exp_val, act_val);
    endtask

    task automatic reset_model();
        for (int k = 0; k < NUM_SLAVES; k++) begin
            model_reg[k] = REG_RESET_BASE + REG_STRIDE * DATA_W'(k);
        end
        model_state   = IDLE;
        start_pending = 1'b0;
        age           = 0;
        exp_dat       = '0;
    endtask

    // Inputs and outputs are both settled at the falling edge
    always @(negedge clk) begin
        exp_ack = 1'b0;
        exp_err = 1'b0;
        // Model held in reset until rst is known low
        if (rst !== 1'b0) begin
            reset_model();
        end else begin
            if (model_state == ACCESS) begin
                age++;
            end
            if (start_pending) begin
                model_state   = ACCESS;
                age           = 0;
                start_pending = 1'b0;
            end

            if (model_state == ACCESS) begin
                idx = int'(acc_adr[SEL_LSB +: SEL_W]);
                if (acc_adr[ADDR_W-1:MAP_TOP_LSB] == '0 && age == 4) begin
                    exp_ack = 1'b1;
                    if (acc_we) begin
                        model_reg[idx] = acc_dat;
                    end else begin
                        exp_dat = model_reg[idx];
                    end
                    model_state = COMPLETE;
                    done_cnt++;
                end else if (acc_adr[ADDR_W-1:MAP_TOP_LSB] != '0 &&
                             age == TIMEOUT_CYCLES + 1) begin
                    exp_err     = 1'b1;
                    model_state = COMPLETE;
                    done_cnt++;
                end
            end

            // Transition taken at the coming rising edge
            if (model_state == IDLE && cyc_i && stb_i) begin
                start_pending = 1'b1;
                acc_adr       = adr_i;
                acc_dat       = wdat_i;
                acc_we        = we_i;
            end else if (model_state == COMPLETE && !stb_i) begin
                model_state = IDLE;
            end

            if (ack_i !== exp_ack) begin
                report_mismatch("wb_ack_o", DATA_W'(exp_ack), DATA_W'(ack_i));
            end
            if (err_i !== exp_err) begin
                report_mismatch("wb_err_o", DATA_W'(exp_err), DATA_W'(err_i));
            end
            if (rdat_i !== exp_dat) begin
                report_mismatch("wb_dat_o", exp_dat, rdat_i);
            end
        end
    end

endmodule

`default_nettype wire

//--- wb_host_tb.sv
// Wishbone host testbench driving seeded random reads and writes into the register bank
`timescale 1ns/1ps
`default_nettype none

module wb_host_tb;

    import wb_bus_pkg::*;
    import wb_map_pkg::*;

    localparam int NUM_TRANS   = 200;
    localparam int CYCLE_LIMIT = NUM_TRANS * (TIMEOUT_CYCLES + 8) + 100;

    logic              clk;
    logic              rst;
    logic [ADDR_W-1:0] wb_adr;
    logic [DATA_W-1:0] wb_dat_w;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [DATA_W-1:0] wb_dat_r;
    logic              wb_ack;
    logic              wb_err;
    int                error_count;
    int                done_count;
    int                trans_count = 0;
    int                cycle_count = 0;

    wb_host_top dut0 (
        .clk      (clk),
        .rst      (rst),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack),
        .wb_err_o (wb_err)
    );

    wb_host_checker checker0 (
        .clk           (clk),
        .rst           (rst),
        .adr_i         (wb_adr),
        .wdat_i        (wb_dat_w),
        .cyc_i         (wb_cyc),
        .stb_i         (wb_stb),
        .we_i          (wb_we),
        .rdat_i        (wb_dat_r),
        .ack_i         (wb_ack),
        .err_i         (wb_err),
        .error_count_o (error_count),
        .done_count_o  (done_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Run limit sized for the slowest access per transaction
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles, an access never finished", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    // One master access, ended by ack or err, then stb low for gap cycles
    task automatic do_access(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat,
                             input logic we, input logic hold_extra, input int gap);
        @(posedge clk);
        #1;
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_we    = we;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        @(negedge clk);
        while (!(wb_ack || wb_err)) begin
            @(negedge clk);
        end
        if (hold_extra) begin
            repeat (2) @(posedge clk);
        end
        @(posedge clk);
        #1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        // Bus lines change while idle, the latched request must not
        wb_dat_w = $urandom();
        repeat (gap - 1) @(posedge clk);
        trans_count++;
    endtask

    initial begin
        logic [31:0]       rnd;
        logic [31:0]       ctl;
        logic [ADDR_W-1:0] adr;
        int                seed_ret;

        seed_ret = $urandom(32'h0257c314);
        rst      = 1'b1;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // First reads of every slave see the reset values
        for (int k = 0; k < NUM_SLAVES; k++) begin
            rnd = $urandom();
            adr = ADDR_W'(k) << SEL_LSB;
            adr[SEL_LSB-1:0] = rnd[SEL_LSB-1:0];
            do_access(adr, $urandom(), 1'b0, 1'b0, 1);
        end

        for (int t = NUM_SLAVES; t < NUM_TRANS; t++) begin
            rnd = $urandom();
            ctl = $urandom();
            if ($urandom_range(0, 99) < 80) begin
                adr = '0;
                adr[MAP_TOP_LSB-1:0] = rnd[MAP_TOP_LSB-1:0];
            end else begin
                adr = rnd;
                if (adr[ADDR_W-1:MAP_TOP_LSB] == '0) begin
                    adr[MAP_TOP_LSB] = 1'b1;
                end
            end
            do_access(adr, $urandom(), ctl[0], ctl[2:1] == 2'b00,
                      int'($urandom_range(1, 3)));
        end

        repeat (4) @(posedge clk);
        if (done_count != trans_count) begin
            $display("Checker counted %0d finished accesses, %0d were issued",
                     done_count, trans_count);
        end
        $display("Transactions: %0d, errors: %0d", trans_count, error_count);
        if (error_count == 0 && done_count == trans_count) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- wb_host.f
wb_bus_pkg.sv
wb_map_pkg.sv
wb_host_ctrl.sv
wb_slave_decoder.sv
wb_reg_slave.sv
wb_response_mux.sv
wb_host_top.sv
wb_host_checker.sv
wb_host_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the Wishbone host testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module wb_host_tb \
    -f wb_host.f \
    -o wb_host_sim

sim_out=$(./obj_dir/wb_host_sim)
echo "$sim_out"

if echo "$sim_out" | grep -q "All tests passed"; then
    echo "Simulation result: PASS"
    exit 0
fi

echo "Simulation result: FAIL"
exit 1
